/* source/odi_pkg.sv */
/*
  Constants and types shared by the ODI bit-error accelerator.
  Addresses and selector codes assume the transceiver ODI and adaptation register map.
  Only the low byte of each register is ever read or written.
*/
`default_nettype none

package odi_pkg;

  // Configuration bus address map
  localparam int addr_width = 10;
  localparam logic [addr_width-1:0] addr_ctrl   = 10'h169;
  localparam logic [addr_width-1:0] addr_select = 10'h14c;
  localparam logic [addr_width-1:0] addr_status = 10'h177;

  // Adaptation status-bus selector codes, written to the low 7 bits of 0x14c
  localparam logic [6:0] sel_status = 7'h2d;
  localparam logic [6:0] sel_err_hi = 7'h2c;
  localparam logic [6:0] sel_err_lo = 7'h2b;
  localparam logic [6:0] sel_bit_hi = 7'h2a;
  localparam logic [6:0] sel_bit_lo = 7'h29;

  localparam int status_ready_bit = 1;

  // Low two bits of the ODI control byte, bit 1 is reset_n and bit 0 is start
  localparam logic [1:0] ctrl_rst_assert  = 2'b00;
  localparam logic [1:0] ctrl_rst_release = 2'b10;
  localparam logic [1:0] ctrl_run         = 2'b11;
  localparam logic [1:0] ctrl_halt        = 2'b10;

  localparam logic [5:0] pause_cycles = 6'd24;
  localparam int adpt_width = 16;

  typedef enum logic [1:0] {
    op_read  = 2'b01,
    op_write = 2'b10
  } odi_op_e;

  typedef enum logic [4:0] {
    st_idle, st_rd_ctrl,
    st_wr_start_0, st_wr_reset_0, st_wr_reset_1, st_wr_start_1, st_wr_stop,
    st_pause_status, st_pause_poll, st_pause_read,
    st_rd_select, st_poll_status,
    st_rd_err_hi, st_rd_err_lo, st_rd_bit_hi, st_rd_bit_lo,
    st_accum
  } odi_state_e;

endpackage

`default_nettype wire

/* source/odi_sequencer.sv */
/*
  Control FSM of the ODI accelerator with one bus command in flight at a time.
  A command is issued the cycle after the previous bus_done.
  Selector writes run during the following pause, which outlasts any write.
*/
`timescale 1ns/1ps
`default_nettype none

module odi_sequencer (
  input  wire logic                            avmm_clk,
  input  wire logic                            avmm_reset,
  input  wire logic                            odi_reset,
  input  wire logic                            count_en,
  input  wire logic                            bus_done,
  input  wire logic [7:0]                      readdata,
  input  wire logic [7:0]                      ctrl_byte,
  input  wire logic                            select_bit7,
  output logic                                 cmd_valid,
  output odi_pkg::odi_op_e                     cmd_op,
  output logic [odi_pkg::addr_width-1:0]       cmd_addr,
  output logic [7:0]                           cmd_data,
  output logic                                 cap_ctrl,
  output logic                                 cap_select,
  output logic                                 cap_err_hi,
  output logic                                 cap_err_lo,
  output logic                                 cap_bit_hi,
  output logic                                 cap_bit_lo,
  output logic                                 accumulate
);
  import odi_pkg::*;

  odi_state_e            state;
  odi_state_e            state_d;
  logic [5:0]            pause_cnt;
  logic [1:0]            readout;
  logic                  in_pause;
  logic                  pause_end;
  logic                  issue;
  odi_op_e               issue_op;
  logic [addr_width-1:0] issue_addr;
  logic [7:0]            issue_data;

  assign in_pause  = (state == st_pause_status) || (state == st_pause_poll) ||
                     (state == st_pause_read);
  assign pause_end = in_pause && (pause_cnt == pause_cycles - 6'd1);

  // Read data is sampled by the capture block in the bus_done cycle
  assign cap_ctrl   = (state == st_rd_ctrl)   && bus_done;
  assign cap_select = (state == st_rd_select) && bus_done;
  assign cap_err_hi = (state == st_rd_err_hi) && bus_done;
  assign cap_err_lo = (state == st_rd_err_lo) && bus_done;
  assign cap_bit_hi = (state == st_rd_bit_hi) && bus_done;
  assign cap_bit_lo = (state == st_rd_bit_lo) && bus_done;
  assign accumulate = (state == st_accum);

  always_comb begin
    state_d    = state;
    issue      = 1'b0;
    issue_op   = op_read;
    issue_addr = addr_ctrl;
    issue_data = 8'h00;
    case (state)
      st_idle, st_accum: begin
        if (count_en) begin
          state_d = st_rd_ctrl;
          issue   = 1'b1;
        end else begin
          state_d = st_idle;
        end
      end
      // Control byte comes straight off the bus for the first write
      st_rd_ctrl: if (bus_done) begin
        state_d    = st_wr_start_0;
        issue      = 1'b1;
        issue_op   = op_write;
        issue_data = {readdata[7:1], 1'b0};
      end
      st_wr_start_0: if (bus_done) begin
        state_d    = st_wr_reset_0;
        issue      = 1'b1;
        issue_op   = op_write;
        issue_data = {ctrl_byte[7:2], ctrl_rst_assert};
      end
      st_wr_reset_0: if (bus_done) begin
        state_d    = st_wr_reset_1;
        issue      = 1'b1;
        issue_op   = op_write;
        issue_data = {ctrl_byte[7:2], ctrl_rst_release};
      end
      st_wr_reset_1: if (bus_done) begin
        state_d    = st_wr_start_1;
        issue      = 1'b1;
        issue_op   = op_write;
        issue_data = {ctrl_byte[7:2], ctrl_run};
      end
      st_wr_start_1: if (bus_done) begin
        state_d    = st_wr_stop;
        issue      = 1'b1;
        issue_op   = op_write;
        issue_data = {ctrl_byte[7:2], ctrl_halt};
      end
      st_wr_stop: if (bus_done) state_d = st_pause_status;
      st_pause_status: if (pause_end) begin
        state_d    = st_rd_select;
        issue      = 1'b1;
        issue_addr = addr_select;
      end
      st_rd_select: if (bus_done) begin
        state_d    = st_pause_poll;
        issue      = 1'b1;
        issue_op   = op_write;
        issue_addr = addr_select;
        issue_data = {readdata[7], sel_status};
      end
      st_pause_poll: if (pause_end) begin
        state_d    = st_poll_status;
        issue      = 1'b1;
        issue_addr = addr_status;
      end
      // Not ready yet, wait another pause and poll again
      st_poll_status: if (bus_done) begin
        if (readdata[status_ready_bit]) begin
          state_d    = st_pause_read;
          issue      = 1'b1;
          issue_op   = op_write;
          issue_addr = addr_select;
          issue_data = {select_bit7, sel_err_hi};
        end else begin
          state_d    = st_pause_poll;
        end
      end
      st_pause_read: if (pause_end) begin
        issue      = 1'b1;
        issue_addr = addr_status;
        case (readout)
          2'd0:    state_d = st_rd_err_hi;
          2'd1:    state_d = st_rd_err_lo;
          2'd2:    state_d = st_rd_bit_hi;
          default: state_d = st_rd_bit_lo;
        endcase
      end
      st_rd_err_hi, st_rd_err_lo, st_rd_bit_hi: if (bus_done) begin
        state_d    = st_pause_read;
        issue      = 1'b1;
        issue_op   = op_write;
        issue_addr = addr_select;
        case (state)
          st_rd_err_hi: issue_data = {select_bit7, sel_err_lo};
          st_rd_err_lo: issue_data = {select_bit7, sel_bit_hi};
          default:      issue_data = {select_bit7, sel_bit_lo};
        endcase
      end
      st_rd_bit_lo: if (bus_done) state_d = st_accum;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      state     <= st_idle;
      cmd_valid <= 1'b0;
      pause_cnt <= 6'd0;
      readout   <= 2'd0;
    end else if (odi_reset) begin
      state     <= st_idle;
      cmd_valid <= 1'b0;
      pause_cnt <= 6'd0;
      readout   <= 2'd0;
    end else begin
      state     <= state_d;
      cmd_valid <= issue;
      pause_cnt <= (in_pause && !pause_end) ? pause_cnt + 6'd1 : 6'd0;
      if (state == st_poll_status) begin
        readout <= 2'd0;
      end else if (state == st_pause_read && pause_end) begin
        readout <= readout + 2'd1;
      end
    end
  end

  // Command fields are loaded with each issued command
  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      cmd_op   <= op_read;
      cmd_addr <= '0;
      cmd_data <= 8'h00;
    end else if (odi_reset) begin
      cmd_op   <= op_read;
      cmd_addr <= '0;
      cmd_data <= 8'h00;
    end else if (issue) begin
      cmd_op   <= issue_op;
      cmd_addr <= issue_addr;
      cmd_data <= issue_data;
    end
  end

endmodule

`default_nettype wire

/* source/odi_bus_master.sv */
/*
  Bus strobe generator for the configuration bus.
  A write strobe lasts exactly one cycle and never waits for waitrequest.
  A read holds until waitrequest is low; bus_done marks valid read data.
*/
`timescale 1ns/1ps
`default_nettype none

module odi_bus_master #(
  parameter int data_width = 32
) (
  input  wire logic                            avmm_clk,
  input  wire logic                            avmm_reset,
  input  wire logic                            odi_reset,
  input  wire logic                            cmd_valid,
  input  wire odi_pkg::odi_op_e                cmd_op,
  input  wire logic [odi_pkg::addr_width-1:0]  cmd_addr,
  input  wire logic [7:0]                      cmd_data,
  input  wire logic                            waitrequest,
  output logic                                 read,
  output logic                                 write,
  output logic [odi_pkg::addr_width-1:0]       address,
  output logic [data_width-1:0]                writedata,
  output logic                                 bus_done
);
  import odi_pkg::*;

  assign bus_done = write || (read && !waitrequest);

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      read      <= 1'b0;
      write     <= 1'b0;
      address   <= '0;
      writedata <= '0;
    end else if (odi_reset) begin
      read      <= 1'b0;
      write     <= 1'b0;
      address   <= '0;
      writedata <= '0;
    end else if (cmd_valid) begin
      read      <= (cmd_op == op_read);
      write     <= (cmd_op == op_write);
      address   <= cmd_addr;
      writedata <= (cmd_op == op_write) ? {{(data_width-8){1'b0}}, cmd_data} : '0;
    end else if (!read || !waitrequest) begin
      // Idle bus shows zero address and data
      read      <= 1'b0;
      write     <= 1'b0;
      address   <= '0;
      writedata <= '0;
    end
  end

endmodule

`default_nettype wire

/* source/odi_count_capture.sv */
/*
  Holds the saved control and select bytes of the current round.
  Error and bit counts arrive high byte first and are cleared at round start.
*/
`timescale 1ns/1ps
`default_nettype none

module odi_count_capture (
  input  wire logic                            avmm_clk,
  input  wire logic                            avmm_reset,
  input  wire logic                            odi_reset,
  input  wire logic [7:0]                      readdata,
  input  wire logic                            cap_ctrl,
  input  wire logic                            cap_select,
  input  wire logic                            cap_err_hi,
  input  wire logic                            cap_err_lo,
  input  wire logic                            cap_bit_hi,
  input  wire logic                            cap_bit_lo,
  output logic [7:0]                           ctrl_byte,
  output logic                                 select_bit7,
  output logic [odi_pkg::adpt_width-1:0]       adpt_errs,
  output logic [odi_pkg::adpt_width-1:0]       adpt_bits
);

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      ctrl_byte   <= 8'h00;
      select_bit7 <= 1'b0;
      adpt_errs   <= '0;
      adpt_bits   <= '0;
    end else if (odi_reset) begin
      ctrl_byte   <= 8'h00;
      select_bit7 <= 1'b0;
      adpt_errs   <= '0;
      adpt_bits   <= '0;
    end else begin
      if (cap_ctrl) begin
        ctrl_byte <= readdata;
        adpt_errs <= '0;
        adpt_bits <= '0;
      end
      if (cap_select) select_bit7 <= readdata[7];
      if (cap_err_hi) adpt_errs[15:8] <= readdata;
      if (cap_err_lo) adpt_errs[7:0]  <= readdata;
      if (cap_bit_hi) adpt_bits[15:8] <= readdata;
      if (cap_bit_lo) adpt_bits[7:0]  <= readdata;
    end
  end

endmodule

`default_nettype wire

/* source/odi_accumulator.sv */
/*
  Bit and error accumulators, count_width+1 bits each.
  done is the top bit of the bit accumulator; once set, both sums freeze.
  snap copies the low count_width bits to the outputs on the next edge.
*/
`timescale 1ns/1ps
`default_nettype none

module odi_accumulator #(
  parameter int count_width = 50
) (
  input  wire logic                            avmm_clk,
  input  wire logic                            avmm_reset,
  input  wire logic                            odi_reset,
  input  wire logic                            accumulate,
  input  wire logic [odi_pkg::adpt_width-1:0]  adpt_bits,
  input  wire logic [odi_pkg::adpt_width-1:0]  adpt_errs,
  input  wire logic                            snap,
  output logic                                 done,
  output logic [count_width-1:0]               bit_count,
  output logic [count_width-1:0]               err_count
);
  import odi_pkg::*;

  logic [count_width:0] bit_acc;
  logic [count_width:0] err_acc;

  assign done = bit_acc[count_width];

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      bit_acc   <= '0;
      err_acc   <= '0;
      bit_count <= '0;
      err_count <= '0;
    end else if (odi_reset) begin
      bit_acc   <= '0;
      err_acc   <= '0;
      bit_count <= '0;
      err_count <= '0;
    end else begin
      // Overflow into the top bit stops both sums
      if (accumulate && !done) begin
        bit_acc <= bit_acc + {{(count_width+1-adpt_width){1'b0}}, adpt_bits};
        err_acc <= err_acc + {{(count_width+1-adpt_width){1'b0}}, adpt_errs};
      end
      if (snap) begin
        bit_count <= bit_acc[count_width-1:0];
        err_count <= err_acc[count_width-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* source/odi_accel_top.sv */
/*
  ODI bit-error accelerator, a master on the transceiver configuration bus.
  Writes are single-cycle strobes and ignore waitrequest; reads wait for it.
  data_width must be at least 8, the upper writedata bits are always zero.
*/
`timescale 1ns/1ps
`default_nettype none

module odi_accel_top #(
  parameter int data_width  = 32,
  parameter int count_width = 50
) (
  input  wire logic                            avmm_clk,
  input  wire logic                            avmm_reset,
  output logic                                 odi_read,
  output logic                                 odi_write,
  output logic [odi_pkg::addr_width-1:0]       odi_address,
  output logic [data_width-1:0]                odi_writedata,
  input  wire logic [7:0]                      odi_readdata,
  input  wire logic                            odi_waitrequest,
  input  wire logic                            odi_count_en,
  input  wire logic                            odi_snap,
  input  wire logic                            odi_reset,
  output logic                                 odi_done,
  output logic [count_width-1:0]               odi_bit_count,
  output logic [count_width-1:0]               odi_err_count
);
  import odi_pkg::*;

  logic                  cmd_valid;
  odi_op_e               cmd_op;
  logic [addr_width-1:0] cmd_addr;
  logic [7:0]            cmd_data;
  logic                  bus_done;
  logic                  cap_ctrl;
  logic                  cap_select;
  logic                  cap_err_hi;
  logic                  cap_err_lo;
  logic                  cap_bit_hi;
  logic                  cap_bit_lo;
  logic                  accumulate;
  logic [7:0]            ctrl_byte;
  logic                  select_bit7;
  logic [adpt_width-1:0] adpt_errs;
  logic [adpt_width-1:0] adpt_bits;

  odi_sequencer odi_sequencer_inst (
    .avmm_clk, .avmm_reset, .odi_reset,
    .count_en (odi_count_en),
    .bus_done, .readdata (odi_readdata), .ctrl_byte, .select_bit7,
    .cmd_valid, .cmd_op, .cmd_addr, .cmd_data,
    .cap_ctrl, .cap_select, .cap_err_hi, .cap_err_lo, .cap_bit_hi, .cap_bit_lo,
    .accumulate
  );

  odi_bus_master #(.data_width(data_width)) odi_bus_master_inst (
    .avmm_clk, .avmm_reset, .odi_reset,
    .cmd_valid, .cmd_op, .cmd_addr, .cmd_data,
    .waitrequest (odi_waitrequest),
    .read (odi_read), .write (odi_write),
    .address (odi_address), .writedata (odi_writedata),
    .bus_done
  );

  odi_count_capture odi_count_capture_inst (
    .avmm_clk, .avmm_reset, .odi_reset,
    .readdata (odi_readdata),
    .cap_ctrl, .cap_select, .cap_err_hi, .cap_err_lo, .cap_bit_hi, .cap_bit_lo,
    .ctrl_byte, .select_bit7, .adpt_errs, .adpt_bits
  );

  odi_accumulator #(.count_width(count_width)) odi_accumulator_inst (
    .avmm_clk, .avmm_reset, .odi_reset,
    .accumulate, .adpt_bits, .adpt_errs,
    .snap (odi_snap),
    .done (odi_done), .bit_count (odi_bit_count), .err_count (odi_err_count)
  );

endmodule

`default_nettype wire

/* bench/odi_xcvr_model.sv */
/*
  Transceiver register model for the ODI accelerator testbench.
  Serves random control, select and count bytes; stretches reads by 0 to 3 cycles.
  round_done pulses with the served counts when the last count byte is read.
*/
`timescale 1ns/1ps
`default_nettype none

module odi_xcvr_model #(
  parameter logic [31:0] seed       = 32'h1,
  parameter int          data_width = 32
) (
  input  wire logic                  avmm_clk,
  input  wire logic                  avmm_reset,
  input  wire logic                  read,
  input  wire logic                  write,
  input  wire logic [9:0]            address,
  input  wire logic [data_width-1:0] writedata,
  output logic [7:0]                 readdata,
  output logic                       waitrequest,
  output logic                       round_done,
  output logic [15:0]                round_bits,
  output logic [15:0]                round_errs,
  output int                         write_count
);
  import odi_pkg::*;

  logic [31:0] rng;
  logic [31:0] rng_next;
  logic [1:0]  wait_cnt;
  logic [1:0]  wait_len;
  logic [1:0]  polls_left;
  logic [6:0]  last_sel;
  logic [7:0]  ctrl_val;
  logic [7:0]  sel_val;
  logic        read_done;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  assign rng_next    = xorshift(rng);
  assign waitrequest = read && (wait_cnt != wait_len);
  assign read_done   = read && !waitrequest;
  assign round_done  = read_done && (address == addr_status) && (last_sel == sel_bit_lo);

  always_comb begin
    readdata = 8'h00;
    case (address)
      addr_ctrl:   readdata = ctrl_val;
      addr_select: readdata = sel_val;
      addr_status: begin
        case (last_sel)
          sel_status: readdata = (polls_left == 2'd0) ? 8'h02 : 8'h00;
          sel_err_hi: readdata = round_errs[15:8];
          sel_err_lo: readdata = round_errs[7:0];
          sel_bit_hi: readdata = round_bits[15:8];
          sel_bit_lo: readdata = round_bits[7:0];
          default:    readdata = 8'h00;
        endcase
      end
      default: readdata = 8'h00;
    endcase
  end

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      rng         <= seed;
      wait_cnt    <= 2'd0;
      wait_len    <= 2'd0;
      polls_left  <= 2'd0;
      last_sel    <= 7'h00;
      ctrl_val    <= 8'h00;
      sel_val     <= 8'h00;
      round_bits  <= 16'h0000;
      round_errs  <= 16'h0000;
      write_count <= 0;
    end else begin
      rng <= rng_next;
      if (!read) begin
        wait_cnt <= 2'd0;
      end else if (waitrequest) begin
        wait_cnt <= wait_cnt + 2'd1;
      end else begin
        wait_cnt <= 2'd0;
        wait_len <= rng[1:0];
        // New round values are drawn once the control byte has been served
        if (address == addr_ctrl) begin
          ctrl_val   <= rng[15:8];
          round_bits <= rng[31:16];
          round_errs <= rng_next[31:16];
        end
        if (address == addr_select) sel_val <= rng[31:24];
        if (address == addr_status && last_sel == sel_status && polls_left != 2'd0) begin
          polls_left <= polls_left - 2'd1;
        end
      end
      if (write) begin
        write_count <= write_count + 1;
        if (address == addr_select) begin
          last_sel <= writedata[6:0];
          if (writedata[6:0] == sel_status) begin
            polls_left <= (rng[5:4] == 2'd3) ? 2'd1 : rng[5:4];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* bench/odi_accel_tb.sv */
/*
  Testbench for the ODI accelerator with count_width 20 so overflow is reachable.
  A bus monitor checks every control and select write as it happens.
*/
`timescale 1ns/1ps
`default_nettype none

module odi_accel_tb;
  import odi_pkg::*;

  localparam int          clk_period     = 20;
  localparam int          count_w        = 20;
  localparam logic [31:0] rng_seed       = 32'hfa53_47cc;
  localparam int          max_rounds     = 80;
  localparam int          timeout_cycles = max_rounds * 400;

  logic               avmm_clk;
  logic               avmm_reset;
  logic               odi_read;
  logic               odi_write;
  logic [9:0]         odi_address;
  logic [31:0]        odi_writedata;
  logic [7:0]         odi_readdata;
  logic               odi_waitrequest;
  logic               odi_count_en;
  logic               odi_snap;
  logic               odi_reset;
  logic               odi_done;
  logic [count_w-1:0] odi_bit_count;
  logic [count_w-1:0] odi_err_count;
  logic               round_done;
  logic [15:0]        round_bits;
  logic [15:0]        round_errs;
  int                 write_count;

  // Expected sums and monitor state
  logic [count_w:0] exp_bits    = '0;
  logic [count_w:0] exp_errs    = '0;
  logic [7:0]       rd_ctrl     = 8'h00;
  logic             sel_b7      = 1'b0;
  int               ctrl_idx    = 0;
  int               sel_idx     = 0;
  int               rounds_seen = 0;
  int               cycles      = 0;
  logic             quiet_watch;
  int               ctrl_checks = 0;
  int               ctrl_errs   = 0;
  int               sel_checks  = 0;
  int               sel_errs    = 0;
  int               quiet_errs  = 0;
  int               test_checks;
  int               test_errors;
  int               target;
  logic [31:0]      exp_w;

  odi_accel_top #(.data_width(32), .count_width(count_w)) odi_accel_top_inst (
    .avmm_clk, .avmm_reset, .odi_read, .odi_write, .odi_address, .odi_writedata,
    .odi_readdata, .odi_waitrequest, .odi_count_en, .odi_snap, .odi_reset,
    .odi_done, .odi_bit_count, .odi_err_count
  );

  odi_xcvr_model #(.seed(rng_seed), .data_width(32)) odi_xcvr_model_inst (
    .avmm_clk, .avmm_reset, .read (odi_read), .write (odi_write),
    .address (odi_address), .writedata (odi_writedata),
    .readdata (odi_readdata), .waitrequest (odi_waitrequest),
    .round_done, .round_bits, .round_errs, .write_count
  );

  function automatic logic [1:0] ctrl_low_bits(input int idx, input logic [7:0] rd);
    case (idx)
      0:       return {rd[1], 1'b0};
      1:       return 2'b00;
      2:       return 2'b10;
      3:       return 2'b11;
      default: return 2'b10;
    endcase
  endfunction

  function automatic logic [6:0] select_code(input int idx);
    case (idx)
      0:       return 7'h2d;
      1:       return 7'h2c;
      2:       return 7'h2b;
      3:       return 7'h2a;
      default: return 7'h29;
    endcase
  endfunction

  initial begin
    avmm_clk = 1'b0;
    forever #(clk_period / 2) avmm_clk = ~avmm_clk;
  end

  always @(posedge avmm_clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Bus monitor, samples on the rising edge before the registers update
  always @(posedge avmm_clk) begin
    if (odi_reset) begin
      exp_bits <= '0;
      exp_errs <= '0;
    end else if (round_done) begin
      rounds_seen <= rounds_seen + 1;
      if (!exp_bits[count_w]) begin
        exp_bits <= exp_bits + {5'd0, round_bits};
        exp_errs <= exp_errs + {5'd0, round_errs};
      end
      if (ctrl_idx != 5 || sel_idx != 5) begin
        $display("Round %0d ended at %0t after %0d control and %0d select writes",
                 rounds_seen + 1, $time, ctrl_idx, sel_idx);
        ctrl_errs <= ctrl_errs + 1;
      end
    end
    if (odi_read && !odi_waitrequest && odi_address == addr_ctrl) begin
      rd_ctrl  <= odi_readdata;
      ctrl_idx <= 0;
    end
    if (odi_read && !odi_waitrequest && odi_address == addr_select) begin
      sel_b7  <= odi_readdata[7];
      sel_idx <= 0;
    end
    if (odi_write && odi_address == addr_ctrl) begin
      exp_w = {24'h0, rd_ctrl[7:2], ctrl_low_bits(ctrl_idx, rd_ctrl)};
      ctrl_checks <= ctrl_checks + 1;
      ctrl_idx    <= ctrl_idx + 1;
      if (ctrl_idx > 4) begin
        $display("Control write %0d at %0t follows a single control read", ctrl_idx, $time);
        ctrl_errs <= ctrl_errs + 1;
      end else if (odi_writedata !== exp_w) begin
        $display("ERROR %0t odi_writedata got %h expected %h", $time, odi_writedata, exp_w);
        ctrl_errs <= ctrl_errs + 1;
      end
    end else if (odi_write && odi_address == addr_select) begin
      exp_w = {24'h0, sel_b7, select_code(sel_idx)};
      sel_checks <= sel_checks + 1;
      sel_idx    <= sel_idx + 1;
      if (odi_writedata !== exp_w) begin
        $display("ERROR %0t odi_writedata got %h expected %h", $time, odi_writedata, exp_w);
        sel_errs <= sel_errs + 1;
      end
    end else if (odi_write) begin
      $display("Write to unexpected address %h at %0t", odi_address, $time);
      sel_errs <= sel_errs + 1;
    end
    if (quiet_watch && (odi_read || odi_write)) begin
      $display("Bus strobe at %0t while count_en is low", $time);
      quiet_errs <= quiet_errs + 1;
    end
  end

  task automatic wait_rounds(input int n);
    target = rounds_seen + n;
    while (rounds_seen < target) @(negedge avmm_clk);
  endtask

  task automatic compare_counts(input string name, input logic exp_done);
    test_checks = test_checks + 3;
    if (odi_bit_count !== exp_bits[count_w-1:0]) begin
      $display("ERROR %0t odi_bit_count got %h expected %h", $time, odi_bit_count,
               exp_bits[count_w-1:0]);
      test_errors = test_errors + 1;
    end
    if (odi_err_count !== exp_errs[count_w-1:0]) begin
      $display("ERROR %0t odi_err_count got %h expected %h", $time, odi_err_count,
               exp_errs[count_w-1:0]);
      test_errors = test_errors + 1;
    end
    if (odi_done !== exp_done) begin
      $display("ERROR %0t odi_done got %b expected %b", $time, odi_done, exp_done);
      test_errors = test_errors + 1;
    end
    $display("%s finished, errors so far %0d", name, test_errors);
  endtask

  task automatic snap_and_compare(input string name, input logic exp_done);
    repeat (5) @(negedge avmm_clk);
    odi_snap = 1'b1;
    @(negedge avmm_clk);
    odi_snap = 1'b0;
    @(negedge avmm_clk);
    compare_counts(name, exp_done);
  endtask

  initial begin
    avmm_reset   = 1'b1;
    odi_count_en = 1'b0;
    odi_snap     = 1'b0;
    odi_reset    = 1'b0;
    quiet_watch  = 1'b0;
    test_checks  = 0;
    test_errors  = 0;
    repeat (4) @(negedge avmm_clk);
    avmm_reset = 1'b0;

    // Random rounds, then stop and snap
    odi_count_en = 1'b1;
    wait_rounds(6);
    odi_count_en = 1'b0;
    snap_and_compare("Test 3 sums after 6 rounds", 1'b0);

    // Run to overflow, then two more rounds that must not change the sums
    odi_count_en = 1'b1;
    while (!odi_done) @(negedge avmm_clk);
    wait_rounds(2);
    odi_count_en = 1'b0;
    snap_and_compare("Test 4 overflow and hold", 1'b1);

    // Soft reset in the middle of a round
    odi_count_en = 1'b1;
    wait_rounds(1);
    repeat (60) @(negedge avmm_clk);
    odi_reset    = 1'b1;
    odi_count_en = 1'b0;
    @(negedge avmm_clk);
    odi_reset   = 1'b0;
    quiet_watch = 1'b1;
    compare_counts("Test 5 outputs after soft reset", 1'b0);
    repeat (300) @(negedge avmm_clk);
    quiet_watch = 1'b0;
    snap_and_compare("Test 5 snap after soft reset", 1'b0);
    $display("Test 5 strobes while idle: %0d", quiet_errs);

    if (ctrl_checks == 0 || sel_checks == 0) begin
      $display("No control or select writes were seen on the bus");
      test_errors = test_errors + 1;
    end
    $display("Test 1 control writes: %0d checked, %0d errors", ctrl_checks, ctrl_errs);
    $display("Test 2 select writes: %0d checked, %0d errors", sel_checks, sel_errs);
    $display("Checks %0d, errors %0d, bus writes %0d",
             test_checks + ctrl_checks + sel_checks,
             test_errors + ctrl_errs + sel_errs + quiet_errs, write_count);
    if (test_errors + ctrl_errs + sel_errs + quiet_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
source/odi_pkg.sv
source/odi_sequencer.sv
source/odi_bus_master.sv
source/odi_count_capture.sv
source/odi_accumulator.sv
source/odi_accel_top.sv
bench/odi_xcvr_model.sv
bench/odi_accel_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the ODI accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module odi_accel_tb -o odi_sim > build.log 2>&1 \
  && ./obj_dir/odi_sim > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "^Result: PASSED$" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
